// ==== verilog/raster_params.svh ====
// frame-buffer resolution, data widths and clear values
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// frame-buffer resolution in pixels
`define FB_HRES 320
`define FB_VRES 180

// one depth word per pixel, also the clear sweep length
`define FB_PIXELS (`FB_HRES * `FB_VRES)

`define ADDR_WIDTH 16
`define DEPTH_WIDTH 12
`define COLOR_WIDTH 16

// values written by the clear sweep
`define DEPTH_FAR {`DEPTH_WIDTH{1'b1}}
`define CLEAR_COLOR {`COLOR_WIDTH{1'b0}}

`endif

// ==== verilog/raster_pkg.sv ====
// fragment and pixel types: pixel address, depth and color
`include "raster_params.svh"

package raster_pkg;

  // linear address, row * FB_HRES + column
  typedef logic [`ADDR_WIDTH-1:0] pix_addr_t;

  // smaller depth is nearer to the viewer
  typedef logic [`DEPTH_WIDTH-1:0] depth_t;

  // RGB565
  typedef logic [`COLOR_WIDTH-1:0] color_t;

endpackage

// ==== verilog/frame_pkg.sv ====
// frame sequencing state type and frame page select type
package frame_pkg;

  // sweep, accept fragments, wait for the last fragment to leave
  typedef enum logic [1:0] {
    CLEARING,
    DRAWING,
    DRAINING
  } frame_state_e;

  // which of the two frame pages is written
  typedef logic frame_sel_t;

endpackage

// ==== verilog/pix_wr_if.sv ====
// interface for depth-tested pixel writes, with source and sink modports
interface pix_wr_if import raster_pkg::*; ();

  logic      valid;
  logic      ready;
  pix_addr_t addr;
  depth_t    depth;
  color_t    color;
  logic      last;
  // low for a rejected fragment that only carries the frame end
  logic      depth_pass;

  modport src (
    output valid, addr, depth, color, last, depth_pass,
    input  ready
  );

  modport dst (
    input  valid, addr, depth, color, last, depth_pass,
    output ready
  );

endinterface

// ==== verilog/depth_buffer.sv ====
// per-pixel depth memory with a registered read port and a write port
`include "raster_params.svh"

module depth_buffer import raster_pkg::*; #(
  parameter int DEPTH = `FB_PIXELS
) (
  input  logic      clk_100_passthrough,
  input  logic      rd_en,
  input  pix_addr_t rd_addr,
  output depth_t    rd_data,
  input  logic      wr_en,
  input  pix_addr_t wr_addr,
  input  depth_t    wr_data
);

  // nearest depth seen so far at each pixel
  depth_t mem [DEPTH];

  // read-first, a same-edge write is seen on the next read
  always_ff @(posedge clk_100_passthrough) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk_100_passthrough) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // the sequencer muxes two write sources, both must stay inside the buffer
  a_wr_addr_range: assert property (
    @(posedge clk_100_passthrough) wr_en |-> (int'(wr_addr) < DEPTH)
  ) else $error("depth write outside buffer, addr %0d", wr_addr);

endmodule

// ==== verilog/depth_test.sv ====
// two-stage depth compare pipeline with back-pressure stall and forwarding
module depth_test import raster_pkg::*; (
  input  logic      clk_100_passthrough,
  input  logic      sys_rst,
  input  logic      frag_valid,
  output logic      frag_ready,
  input  pix_addr_t frag_addr,
  input  depth_t    frag_depth,
  input  color_t    frag_color,
  input  logic      frag_last,
  input  logic      drawing,
  output logic      rd_en,
  output pix_addr_t rd_addr,
  input  depth_t    rd_data,
  pix_wr_if.src     wr
);

  // stage 1 waits on the depth read
  logic      s1_valid;
  pix_addr_t s1_addr;
  depth_t    s1_depth;
  color_t    s1_color;
  logic      s1_last;

  // stage 2 compares and drives the output
  logic      s2_valid;
  pix_addr_t s2_addr;
  depth_t    s2_depth;
  color_t    s2_color;
  logic      s2_last;

  // older fragment wrote the same pixel on the edge this read was taken
  logic      fwd_hit;
  depth_t    fwd_depth;

  depth_t    stored_depth;
  logic      stall;
  logic      s2_writes;
  logic      last_pending;

  assign stored_depth  = fwd_hit ? fwd_depth : rd_data;
  assign wr.depth_pass = (s2_depth < stored_depth);
  // rejected fragments vanish here unless they close the frame
  assign wr.valid      = s2_valid && (wr.depth_pass || s2_last);
  assign wr.addr       = s2_addr;
  assign wr.depth      = s2_depth;
  assign wr.color      = s2_color;
  assign wr.last       = s2_last;

  assign stall     = wr.valid && !wr.ready;
  assign s2_writes = wr.valid && wr.ready && wr.depth_pass;

  // nothing from the next frame may enter behind a last fragment
  assign last_pending = (s1_valid && s1_last) || (s2_valid && s2_last);
  assign frag_ready   = drawing && !stall && !last_pending;

  // read is held during a stall so rd_data keeps stage 2's stored depth
  assign rd_en   = s1_valid && !stall;
  assign rd_addr = s1_addr;

  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      fwd_hit  <= 1'b0;
    end else if (!stall) begin
      s1_valid <= frag_valid && frag_ready;
      s2_valid <= s1_valid;
      fwd_hit  <= s1_valid && s2_writes && (s2_addr == s1_addr);
    end
  end

  always_ff @(posedge clk_100_passthrough) begin
    if (!stall) begin
      if (frag_ready) begin
        s1_addr  <= frag_addr;
        s1_depth <= frag_depth;
        s1_color <= frag_color;
        s1_last  <= frag_last;
      end
      s2_addr   <= s1_addr;
      s2_depth  <= s1_depth;
      s2_color  <= s1_color;
      s2_last   <= s1_last;
      fwd_depth <= s2_depth;
    end
  end

  // held output includes the compare result, so the memory read must hold too
  a_stall_hold: assert property (
    @(posedge clk_100_passthrough) disable iff (sys_rst)
    stall |=> (s2_valid && $stable(s2_addr) && $stable(s2_depth) &&
               $stable(s2_color) && $stable(s2_last) && $stable(wr.depth_pass))
  ) else $error("stage 2 changed while stalled");

  // the sequencer leaves DRAWING only for a last fragment in stage 2
  a_drawing_ends_on_last: assert property (
    @(posedge clk_100_passthrough) disable iff (sys_rst)
    $fell(drawing) |-> $past(s2_valid && s2_last)
  ) else $error("drawing ended without a last fragment");

endmodule

// ==== verilog/frame_sequencer.sv ====
// frame FSM, clear sweep counter, frame-buffer and depth write muxing
`include "raster_params.svh"

module frame_sequencer import raster_pkg::*, frame_pkg::*; (
  input  logic       clk_100_passthrough,
  input  logic       sys_rst,
  pix_wr_if.dst      wr,
  output logic       drawing,
  output logic       fb_valid,
  input  logic       fb_ready,
  output pix_addr_t  fb_addr,
  output color_t     fb_color,
  output frame_sel_t fb_frame,
  output logic       dw_en,
  output pix_addr_t  dw_addr,
  output depth_t     dw_data
);

  frame_state_e state;
  pix_addr_t    clr_addr;
  logic         fb_xfer;
  logic         sweep_done;
  logic         last_done;

  assign drawing    = (state == DRAWING);
  assign fb_xfer    = fb_valid && fb_ready;
  assign sweep_done = fb_xfer && (clr_addr == pix_addr_t'(`FB_PIXELS - 1));
  assign last_done  = wr.valid && wr.ready && wr.last;

  always_comb begin
    if (state == CLEARING) begin
      fb_valid = 1'b1;
      fb_addr  = clr_addr;
      fb_color = `CLEAR_COLOR;
      dw_data  = `DEPTH_FAR;
      wr.ready = 1'b0;
    end else begin
      fb_valid = wr.valid && wr.depth_pass;
      fb_addr  = wr.addr;
      fb_color = wr.color;
      dw_data  = wr.depth;
      // a rejected last fragment is consumed without a frame-buffer write
      wr.ready = fb_ready || !wr.depth_pass;
    end
  end

  // every frame-buffer write also updates the depth memory
  assign dw_en   = fb_xfer;
  assign dw_addr = fb_addr;

  always_ff @(posedge clk_100_passthrough) begin
    if (sys_rst) begin
      state    <= CLEARING;
      clr_addr <= '0;
      fb_frame <= 1'b0;
    end else begin
      case (state)
        CLEARING: begin
          if (sweep_done) begin
            state    <= DRAWING;
            clr_addr <= '0;
          end else if (fb_xfer) begin
            clr_addr <= clr_addr + 1'b1;
          end
        end
        DRAWING: begin
          if (last_done) begin
            state    <= CLEARING;
            fb_frame <= ~fb_frame;
          end else if (wr.valid && wr.last) begin
            // last fragment waits on the frame buffer
            state <= DRAINING;
          end
        end
        DRAINING: begin
          if (last_done) begin
            state    <= CLEARING;
            fb_frame <= ~fb_frame;
          end
        end
        default: state <= CLEARING;
      endcase
    end
  end

  // the pipeline is empty while the sweep owns the frame buffer
  a_no_frag_in_sweep: assert property (
    @(posedge clk_100_passthrough) disable iff (sys_rst)
    (state == CLEARING) |-> !wr.valid
  ) else $error("tested fragment waiting during the clear sweep");

endmodule

// ==== verilog/z_raster_top.sv ====
// depth-test and frame-clear core: pipeline, depth memory and frame sequencer
module z_raster_top import raster_pkg::*, frame_pkg::*; (
  input  logic       clk_100_passthrough,
  input  logic       sys_rst,
  input  logic       frag_valid,
  output logic       frag_ready,
  input  pix_addr_t  frag_addr,
  input  depth_t     frag_depth,
  input  color_t     frag_color,
  input  logic       frag_last,
  output logic       fb_valid,
  input  logic       fb_ready,
  output pix_addr_t  fb_addr,
  output color_t     fb_color,
  output frame_sel_t fb_frame
);

  logic      drawing;
  logic      rd_en;
  pix_addr_t rd_addr;
  depth_t    rd_data;
  logic      dw_en;
  pix_addr_t dw_addr;
  depth_t    dw_data;

  // tested fragments from the pipeline to the sequencer
  pix_wr_if wr_bus ();

  depth_test u_test (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .frag_valid         (frag_valid),
    .frag_ready         (frag_ready),
    .frag_addr          (frag_addr),
    .frag_depth         (frag_depth),
    .frag_color         (frag_color),
    .frag_last          (frag_last),
    .drawing            (drawing),
    .rd_en              (rd_en),
    .rd_addr            (rd_addr),
    .rd_data            (rd_data),
    .wr                 (wr_bus)
  );

  depth_buffer u_zbuf (
    .clk_100_passthrough(clk_100_passthrough),
    .rd_en              (rd_en),
    .rd_addr            (rd_addr),
    .rd_data            (rd_data),
    .wr_en              (dw_en),
    .wr_addr            (dw_addr),
    .wr_data            (dw_data)
  );

  frame_sequencer u_seq (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst),
    .wr                 (wr_bus),
    .drawing            (drawing),
    .fb_valid           (fb_valid),
    .fb_ready           (fb_ready),
    .fb_addr            (fb_addr),
    .fb_color           (fb_color),
    .fb_frame           (fb_frame),
    .dw_en              (dw_en),
    .dw_addr            (dw_addr),
    .dw_data            (dw_data)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock at 100 MHz and synchronous reset held for the first cycles
module tb_clock_gen (
  output logic clk_100_passthrough,
  output logic sys_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 8;

  // 10 ns period
  initial begin
    clk_100_passthrough = 1'b0;
    forever #5 clk_100_passthrough = ~clk_100_passthrough;
  end

  // released just after an edge, like the other stimulus
  initial begin
    sys_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_100_passthrough);
    #1;
    sys_rst = 1'b0;
  end
endmodule

// ==== tests/z_raster_tb.sv ====
// directed tests, fb monitor, depth model and watchdog for z_raster_top
`include "raster_params.svh"

module z_raster_tb import raster_pkg::*, frame_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // four sweeps at half rate plus room for the fragment tests
  localparam int WATCHDOG_CYCLES = 4 * `FB_PIXELS * 2 + 20000;
  // two-cycle pipeline latency plus margin for a stray write
  localparam int DRAIN_CYCLES = 4;

  logic       clk_100_passthrough, sys_rst;
  logic       frag_valid, frag_ready, frag_last, fb_valid, fb_ready, bp_random;
  pix_addr_t  frag_addr, fb_addr;
  depth_t     frag_depth;
  color_t     frag_color, fb_color;
  frame_sel_t fb_frame;

  // writes seen on the fb port and writes the model expects
  pix_addr_t  mon_addr[$], exp_addr[$];
  color_t     mon_color[$], exp_color[$];
  frame_sel_t mon_frame[$], exp_frame[$];
  // nearest depth per pixel since the last clear
  // a pixel with no entry is at far depth
  depth_t     model_depth[pix_addr_t];
  frame_sel_t model_frame;
  int         mismatches;
  int         failures;

  tb_clock_gen clk_gen (
    .clk_100_passthrough(clk_100_passthrough),
    .sys_rst            (sys_rst)
  );

  z_raster_top uut (.*);

  // outputs settle by mid-cycle and the transfer happens at the next edge
  always @(negedge clk_100_passthrough) begin
    if (!sys_rst && fb_valid && fb_ready) begin
      mon_addr.push_back(fb_addr);
      mon_color.push_back(fb_color);
      mon_frame.push_back(fb_frame);
    end
  end

  initial begin
    fb_ready = 1'b1;
    forever begin
      @(posedge clk_100_passthrough);
      #1;
      fb_ready = bp_random ? ($urandom % 2 == 1) : 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_100_passthrough);
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  task automatic wait_mid_cycle();
    @(negedge clk_100_passthrough);
    #1;
  endtask

  task automatic next_drive();
    @(posedge clk_100_passthrough);
    #1;
  endtask

  task automatic check_addr(input pix_addr_t got, input pix_addr_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s, fb_addr %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_color(input color_t got, input color_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s, fb_color %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(input frame_sel_t got, input frame_sel_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s, fb_frame %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s, %0d writes, expected %0d", $time, what, got, exp);
    end
  endtask

  // a fragment writes only when strictly nearer than the stored depth
  function automatic void predict_write(pix_addr_t addr, depth_t depth, color_t color,
                                        logic last);
    depth_t stored;
    stored = model_depth.exists(addr) ? model_depth[addr] : `DEPTH_FAR;
    if (depth < stored) begin
      model_depth[addr] = depth;
      exp_addr.push_back(addr);
      exp_color.push_back(color);
      exp_frame.push_back(model_frame);
    end
    // frame end clears the buffer and flips the page
    if (last) begin
      model_depth.delete();
      model_frame = ~model_frame;
    end
  endfunction

  // starts at a drive point and returns at the drive point after acceptance
  task automatic send_frag(input pix_addr_t addr, input depth_t depth, input color_t color,
                           input logic last);
    logic accepted;
    predict_write(addr, depth, color, last);
    frag_valid = 1'b1;
    frag_addr  = addr;
    frag_depth = depth;
    frag_color = color;
    frag_last  = last;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk_100_passthrough);
      accepted = frag_ready;
      next_drive();
    end
    frag_valid = 1'b0;
    frag_last  = 1'b0;
  endtask

  task automatic compare_writes(input string what);
    int n;
    n = (mon_addr.size() < exp_addr.size()) ? mon_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      check_addr(mon_addr.pop_front(), exp_addr.pop_front(), what);
      check_color(mon_color.pop_front(), exp_color.pop_front(), what);
      check_frame(mon_frame.pop_front(), exp_frame.pop_front(), what);
    end
  endtask

  task automatic wait_drain(input string what);
    wait_mid_cycle();
    bp_random = 1'b0;
    while (mon_addr.size() < exp_addr.size()) wait_mid_cycle();
    repeat (DRAIN_CYCLES) wait_mid_cycle();
    check_count(mon_addr.size(), exp_addr.size(), what);
    compare_writes(what);
    mon_addr.delete();
    mon_color.delete();
    mon_frame.delete();
    exp_addr.delete();
    exp_color.delete();
    exp_frame.delete();
  endtask

  // pending fragment writes come first and then one full sweep on the given page
  task automatic verify_clear_sweep(input frame_sel_t frame, input string what);
    int  total;
    logic ready_seen;
    total      = exp_addr.size() + `FB_PIXELS;
    ready_seen = 1'b0;
    while (mon_addr.size() < total) begin
      wait_mid_cycle();
      if (frag_ready && !ready_seen) begin
        failures++;
        ready_seen = 1'b1;
        $display("Error at %0t ns: %s, frag_ready rose before the sweep ended", $time, what);
      end
    end
    compare_writes(what);
    for (int i = 0; i < `FB_PIXELS; i++) begin
      check_addr(mon_addr.pop_front(), pix_addr_t'(i), what);
      check_color(mon_color.pop_front(), `CLEAR_COLOR, what);
      check_frame(mon_frame.pop_front(), frame, what);
    end
    wait_mid_cycle();
    if (frag_ready !== 1'b1) begin
      failures++;
      $display("Error at %0t ns: %s, frag_ready did not rise after the sweep", $time, what);
    end
    check_count(mon_addr.size(), 0, {what, ", writes after the sweep"});
  endtask

  task automatic reset_sweep();
    verify_clear_sweep(model_frame, "sweep after reset");
  endtask

  task automatic distinct_pixels();
    next_drive();
    for (int i = 0; i < 12; i++) begin
      send_frag(pix_addr_t'(i * 997 + 13), depth_t'(100 + i * 50), color_t'($urandom), 1'b0);
    end
    wait_drain("distinct pixels");
  endtask

  task automatic depth_order();
    depth_t seq [4] = '{100, 200, 100, 50};
    next_drive();
    foreach (seq[i]) begin
      send_frag(pix_addr_t'(1234), seq[i], color_t'($urandom), 1'b0);
      repeat (3) next_drive();
    end
    wait_drain("depth order, spaced");
    // back-to-back sends make the compare use the depth written one edge earlier
    next_drive();
    foreach (seq[i]) send_frag(pix_addr_t'(1235), seq[i], color_t'($urandom), 1'b0);
    wait_drain("depth order, back to back");
  endtask

  task automatic random_backpressure();
    wait_mid_cycle();
    bp_random = 1'b1;
    next_drive();
    for (int i = 0; i < 60; i++) begin
      send_frag(pix_addr_t'(1000 + ($urandom % 6) * 321), depth_t'($urandom),
                color_t'($urandom), 1'b0);
      if ($urandom % 4 == 0) next_drive();
    end
    wait_drain("random back-pressure");
  endtask

  task automatic frame_end();
    next_drive();
    send_frag(pix_addr_t'(3000), depth_t'(300), color_t'($urandom), 1'b1);
    verify_clear_sweep(model_frame, "sweep after last fragment");
    // pixel 1234 held depth 50 in the previous frame
    next_drive();
    send_frag(pix_addr_t'(1234), depth_t'(4000), color_t'($urandom), 1'b0);
    wait_drain("far fragment after clear");
    bp_random = 1'b1;
    next_drive();
    send_frag(pix_addr_t'(1234), depth_t'(4000), color_t'($urandom), 1'b1);
    verify_clear_sweep(model_frame, "sweep after rejected last fragment");
    bp_random = 1'b0;
  endtask

  initial begin
    frag_valid  = 1'b0;
    frag_addr   = '0;
    frag_depth  = '0;
    frag_color  = '0;
    frag_last   = 1'b0;
    bp_random   = 1'b0;
    model_frame = 1'b0;
    mismatches  = 0;
    failures    = 0;
    void'($urandom(93080));
    @(negedge sys_rst);
    reset_sweep();
    distinct_pixels();
    depth_order();
    random_backpressure();
    frame_end();
    $display("Done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end
endmodule

// ==== z_raster.f ====
+incdir+verilog
verilog/raster_pkg.sv
verilog/frame_pkg.sv
verilog/pix_wr_if.sv
verilog/depth_buffer.sv
verilog/depth_test.sv
verilog/frame_sequencer.sv
verilog/z_raster_top.sv
tests/tb_clock_gen.sv
tests/z_raster_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module z_raster_tb \
	  -f z_raster.f -Mdir obj_dir
	@out="$$(./obj_dir/Vz_raster_tb)"; echo "$$out"; \
	  echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
